/* decode_stage.sv */
`include "rv_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  wire                 clk,
    input  wire                 rst,
    input  wire [`XLEN-1:0]     instr_d_i,
    input  wire [`XLEN-1:0]     pc_d_i,
    input  wire [`XLEN-1:0]     pc_plus4_d_i,
    input  wire                 valid_d_i,
    input  wire                 wb_en_i,
    input  wire [4:0]           wb_rd_i,
    input  wire [`XLEN-1:0]     wb_data_i,
    hazard_if.decode            hz,
    output rv_pkg::ctrl_t       ctrl_e_o,
    output logic [`XLEN-1:0]    rs1_val_e_o,
    output logic [`XLEN-1:0]    rs2_val_e_o,
    output logic [`XLEN-1:0]    imm_e_o,
    output logic [`XLEN-1:0]    pc_e_o,
    output logic [`XLEN-1:0]    pc_plus4_e_o,
    output logic [4:0]          rd_e_o,
    output logic [4:0]          rs1_e_o,
    output logic [4:0]          rs2_e_o,
    output logic [`XLEN-1:0]    a0_o
);
    import rv_pkg::*;

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [4:0]       rs1, rs2, rd;
    ctrl_t            ctrl_d;
    alu_op_e          alu_f3;
    logic [`XLEN-1:0] imm_d, rs1_val, rs2_val;
    logic [`XLEN-1:0] regs [0:`NREGS-1];

    assign opcode = opcode_e'(instr_d_i[6:0]);
    assign funct3 = instr_d_i[14:12];
    assign rs1    = instr_d_i[19:15];
    assign rs2    = instr_d_i[24:20];
    assign rd     = instr_d_i[11:7];

    // alu operation from funct3, shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b000:  alu_f3 = (opcode == OPC_OP && instr_d_i[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_f3 = ALU_SLL;
            3'b010:  alu_f3 = ALU_SLT;
            3'b100:  alu_f3 = ALU_XOR;
            3'b101:  alu_f3 = ALU_SRL;
            3'b110:  alu_f3 = ALU_OR;
            default: alu_f3 = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl_d = '0;
        imm_d  = '0;
        case (opcode)
            OPC_OP: begin
                ctrl_d.reg_wr = 1'b1;
                ctrl_d.alu_op = alu_f3;
            end
            OPC_OP_IMM: begin
                ctrl_d.reg_wr      = 1'b1;
                ctrl_d.alu_src_imm = 1'b1;
                ctrl_d.alu_op      = alu_f3;
                imm_d              = {{20{instr_d_i[31]}}, instr_d_i[31:20]};
            end
            OPC_LUI: begin
                ctrl_d.reg_wr      = 1'b1;
                ctrl_d.alu_src_imm = 1'b1;
                ctrl_d.alu_op      = ALU_PASS_B;
                imm_d              = {instr_d_i[31:12], 12'b0};
            end
            OPC_LOAD: begin
                ctrl_d.reg_wr      = 1'b1;
                ctrl_d.mem_rd      = 1'b1;
                ctrl_d.alu_src_imm = 1'b1;
                ctrl_d.res_sel     = RES_MEM;
                imm_d              = {{20{instr_d_i[31]}}, instr_d_i[31:20]};
            end
            OPC_STORE: begin
                ctrl_d.mem_wr      = 1'b1;
                ctrl_d.alu_src_imm = 1'b1;
                imm_d = {{20{instr_d_i[31]}}, instr_d_i[31:25], instr_d_i[11:7]};
            end
            OPC_BRANCH: begin
                ctrl_d.branch    = 1'b1;
                ctrl_d.branch_ne = funct3[0];  // bne
                imm_d = {{20{instr_d_i[31]}}, instr_d_i[7], instr_d_i[30:25],
                         instr_d_i[11:8], 1'b0};
            end
            OPC_JAL: begin
                ctrl_d.reg_wr  = 1'b1;
                ctrl_d.jump    = 1'b1;
                ctrl_d.res_sel = RES_LINK;
                imm_d = {{12{instr_d_i[31]}}, instr_d_i[19:12], instr_d_i[20],
                         instr_d_i[30:21], 1'b0};
            end
            OPC_JALR: begin
                ctrl_d.reg_wr  = 1'b1;
                ctrl_d.jump    = 1'b1;
                ctrl_d.jalr    = 1'b1;
                ctrl_d.res_sel = RES_LINK;
                imm_d          = {{20{instr_d_i[31]}}, instr_d_i[31:20]};
            end
            default: ctrl_d = '0;  // unsupported opcode retires as nop
        endcase
        if (!valid_d_i) begin
            ctrl_d = '0;
        end
    end

    // register file, written at the edge closing writeback
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && wb_rd_i != 5'd0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // bypass gives write-before-read in the same cycle
    assign rs1_val = (rs1 == 5'd0) ? '0 :
                     (wb_en_i && wb_rd_i == rs1) ? wb_data_i : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 :
                     (wb_en_i && wb_rd_i == rs2) ? wb_data_i : regs[rs2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a0_o <= '0;
        end else begin
            a0_o <= regs[10];  // x10
        end
    end

    assign hz.rs1_d = rs1;
    assign hz.rs2_d = rs2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl_e_o <= '0;
        end else if (hz.flush_e || hz.stall) begin
            ctrl_e_o <= '0;  // bubble
        end else begin
            ctrl_e_o <= ctrl_d;
        end
    end

    always_ff @(posedge clk) begin
        rs1_val_e_o  <= rs1_val;
        rs2_val_e_o  <= rs2_val;
        imm_e_o      <= imm_d;
        pc_e_o       <= pc_d_i;
        pc_plus4_e_o <= pc_plus4_d_i;
        rd_e_o       <= rd;
        rs1_e_o      <= rs1;
        rs2_e_o      <= rs2;
    end

endmodule

`default_nettype wire

/* execute_stage.sv */
`include "rv_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  wire                 clk,
    input  wire                 rst,
    input  wire rv_pkg::ctrl_t  ctrl_e_i,
    input  wire [`XLEN-1:0]     rs1_val_e_i,
    input  wire [`XLEN-1:0]     rs2_val_e_i,
    input  wire [`XLEN-1:0]     imm_e_i,
    input  wire [`XLEN-1:0]     pc_e_i,
    input  wire [`XLEN-1:0]     pc_plus4_e_i,
    input  wire [4:0]           rd_e_i,
    input  wire [4:0]           rs1_e_i,
    input  wire [4:0]           rs2_e_i,
    input  wire [`XLEN-1:0]     wb_data_i,
    hazard_if.execute           hz,
    output logic                redirect_o,
    output logic [`XLEN-1:0]    target_o,
    output rv_pkg::ctrl_t       ctrl_m_o,
    output logic [`XLEN-1:0]    alu_result_m_o,
    output logic [`XLEN-1:0]    store_data_m_o,
    output logic [`XLEN-1:0]    pc_plus4_m_o,
    output logic [4:0]          rd_m_o
);
    import rv_pkg::*;

    logic [`XLEN-1:0] op_a, fwd_b_val, op_b, alu_res;
    logic             eq, taken;

    // forwarding muxes
    always_comb begin
        case (hz.fwd_a)
            FWD_MEM: op_a = alu_result_m_o;
            FWD_WB:  op_a = wb_data_i;
            default: op_a = rs1_val_e_i;
        endcase
        case (hz.fwd_b)
            FWD_MEM: fwd_b_val = alu_result_m_o;
            FWD_WB:  fwd_b_val = wb_data_i;
            default: fwd_b_val = rs2_val_e_i;
        endcase
    end

    assign op_b = ctrl_e_i.alu_src_imm ? imm_e_i : fwd_b_val;

    always_comb begin
        case (ctrl_e_i.alu_op)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // beq/bne compare on the forwarded registers
    assign eq         = (op_a == fwd_b_val);
    assign taken      = ctrl_e_i.branch && (eq != ctrl_e_i.branch_ne);
    assign redirect_o = taken || ctrl_e_i.jump;
    assign target_o   = ctrl_e_i.jalr ? ((op_a + imm_e_i) & ~32'd1) : (pc_e_i + imm_e_i);

    assign hz.rs1_e      = rs1_e_i;
    assign hz.rs2_e      = rs2_e_i;
    assign hz.rd_e       = rd_e_i;
    assign hz.mem_rd_e   = ctrl_e_i.mem_rd;
    assign hz.redirect_e = redirect_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl_m_o <= '0;
        end else begin
            ctrl_m_o <= ctrl_e_i;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_m_o <= alu_res;
        store_data_m_o <= fwd_b_val;
        pc_plus4_m_o   <= pc_plus4_e_i;
        rd_m_o         <= rd_e_i;
    end

endmodule

`default_nettype wire

/* fetch_stage.sv */
`include "rv_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  wire                clk,
    input  wire                rst,
    input  wire                trigger_i,
    input  wire                imem_we_i,
    input  wire [`IMEM_AW-1:0] imem_addr_i,
    input  wire [`XLEN-1:0]    imem_wdata_i,
    input  wire                redirect_i,
    input  wire [`XLEN-1:0]    target_i,
    hazard_if.fetch            hz,
    output logic [`XLEN-1:0]   instr_d_o,
    output logic [`XLEN-1:0]   pc_d_o,
    output logic [`XLEN-1:0]   pc_plus4_d_o,
    output logic               valid_d_o
);

    logic             trig_q;
    logic [`XLEN-1:0] pc_q, pc_plus4, pc_next, instr_f;
    logic [`XLEN-1:0] imem [0:`IMEM_WORDS-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trig_q <= 1'b0;
        end else if (trigger_i) begin
            trig_q <= 1'b1;   // sticky until next reset
        end
    end

    assign pc_plus4 = pc_q + 32'd4;
    assign pc_next  = redirect_i ? target_i : pc_plus4;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= `RESET_PC;
        end else if (trig_q && !hz.stall) begin
            pc_q <= pc_next;
        end
    end

    // program load, closed once running
    always_ff @(posedge clk) begin
        if (imem_we_i && !trig_q) begin
            imem[imem_addr_i] <= imem_wdata_i;
        end
    end

    assign instr_f = imem[pc_q[`IMEM_AW+1:2]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_d_o <= 1'b0;
        end else if (hz.flush_d) begin
            valid_d_o <= 1'b0;  // wrong-path fetch
        end else if (!hz.stall) begin
            valid_d_o <= trig_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!hz.stall) begin
            instr_d_o    <= instr_f;
            pc_d_o       <= pc_q;
            pc_plus4_d_o <= pc_plus4;
        end
    end

endmodule

`default_nettype wire

/* hazard_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface hazard_if;
    import rv_pkg::*;

    logic       stall;
    logic       flush_d;
    logic       flush_e;
    fwd_sel_e   fwd_a;
    fwd_sel_e   fwd_b;
    logic [4:0] rs1_d, rs2_d;        // sources in decode
    logic [4:0] rs1_e, rs2_e, rd_e;  // instruction in execute
    logic       mem_rd_e;
    logic       redirect_e;
    logic [4:0] rd_m, rd_w;
    logic       reg_wr_m, reg_wr_w;

    modport hazard (
        input  rs1_d, rs2_d, rs1_e, rs2_e, rd_e, mem_rd_e, redirect_e,
        input  rd_m, reg_wr_m, rd_w, reg_wr_w,
        output stall, flush_d, flush_e, fwd_a, fwd_b
    );
    modport fetch   (input stall, flush_d);
    modport decode  (input stall, flush_e, output rs1_d, rs2_d);
    modport execute (input fwd_a, fwd_b, output rs1_e, rs2_e, rd_e, mem_rd_e, redirect_e);
    modport mem_wb  (output rd_m, reg_wr_m, rd_w, reg_wr_w);

endinterface

`default_nettype wire

/* hazard_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    hazard_if.hazard hz
);
    import rv_pkg::*;

    // newest producer wins, x0 never forwards
    function automatic fwd_sel_e fwd_pick(
        input logic [4:0] rs,
        input logic [4:0] rd_m,
        input logic       wr_m,
        input logic [4:0] rd_w,
        input logic       wr_w
    );
        if (rs == 5'd0) begin
            return FWD_REG;
        end
        if (wr_m && rd_m == rs) begin
            return FWD_MEM;
        end
        if (wr_w && rd_w == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        hz.fwd_a = fwd_pick(hz.rs1_e, hz.rd_m, hz.reg_wr_m, hz.rd_w, hz.reg_wr_w);
        hz.fwd_b = fwd_pick(hz.rs2_e, hz.rd_m, hz.reg_wr_m, hz.rd_w, hz.reg_wr_w);
    end

    // load in execute feeding the instruction in decode
    assign hz.stall = hz.mem_rd_e && (hz.rd_e != 5'd0) &&
                      (hz.rd_e == hz.rs1_d || hz.rd_e == hz.rs2_d);

    assign hz.flush_d = hz.redirect_e;
    assign hz.flush_e = hz.redirect_e;

endmodule

`default_nettype wire

/* mem_wb_stage.sv */
`include "rv_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage (
    input  wire                 clk,
    input  wire                 rst,
    input  wire rv_pkg::ctrl_t  ctrl_m_i,
    input  wire [`XLEN-1:0]     alu_result_m_i,
    input  wire [`XLEN-1:0]     store_data_m_i,
    input  wire [`XLEN-1:0]     pc_plus4_m_i,
    input  wire [4:0]           rd_m_i,
    hazard_if.mem_wb            hz,
    output logic                wb_en_o,
    output logic [4:0]          wb_rd_o,
    output logic [`XLEN-1:0]    wb_data_o
);
    import rv_pkg::*;

    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]   dmem [0:`DMEM_WORDS-1];
    logic [DMEM_AW-1:0] dmem_idx;
    logic [`XLEN-1:0]   rdata_m, alu_w, rdata_w, pc_plus4_w;
    res_sel_e           res_sel_w;

    assign dmem_idx = alu_result_m_i[DMEM_AW+1:2];  // word address
    assign rdata_m  = dmem[dmem_idx];

    always_ff @(posedge clk) begin
        if (ctrl_m_i.mem_wr) begin
            dmem[dmem_idx] <= store_data_m_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_en_o   <= 1'b0;
            res_sel_w <= RES_ALU;
        end else begin
            wb_en_o   <= ctrl_m_i.reg_wr;
            res_sel_w <= ctrl_m_i.res_sel;
        end
    end

    always_ff @(posedge clk) begin
        alu_w      <= alu_result_m_i;
        rdata_w    <= rdata_m;
        pc_plus4_w <= pc_plus4_m_i;
        wb_rd_o    <= rd_m_i;
    end

    always_comb begin
        case (res_sel_w)
            RES_MEM:  wb_data_o = rdata_w;
            RES_LINK: wb_data_o = pc_plus4_w;  // jal/jalr return address
            default:  wb_data_o = alu_w;
        endcase
    end

    assign hz.rd_m     = rd_m_i;
    assign hz.reg_wr_m = ctrl_m_i.reg_wr;
    assign hz.rd_w     = wb_rd_o;
    assign hz.reg_wr_w = wb_en_o;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" \
    && verilator --binary --timing --timescale 1ns/1ns -f tb.f --top-module tb_rv_core \
    && ./obj_dir/Vtb_rv_core | tee /dev/stderr | grep -qF "=== PASS ===" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* rv_core_top.sv */
`include "rv_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module rv_core_top (
    input  wire                clk,
    input  wire                rst,
    input  wire                trigger_i,
    input  wire                imem_we_i,
    input  wire [`IMEM_AW-1:0] imem_addr_i,
    input  wire [`XLEN-1:0]    imem_wdata_i,
    output logic [`XLEN-1:0]   a0_o
);
    import rv_pkg::*;

    hazard_if hz ();

    logic [`XLEN-1:0] instr_d, pc_d, pc_plus4_d;
    logic             valid_d;
    ctrl_t            ctrl_e, ctrl_m;
    logic [`XLEN-1:0] rs1_val_e, rs2_val_e, imm_e, pc_e, pc_plus4_e;
    logic [4:0]       rd_e, rs1_e, rs2_e, rd_m, wb_rd;
    logic             redirect_e, wb_en;
    logic [`XLEN-1:0] target_e, alu_result_m, store_data_m, pc_plus4_m, wb_data;

    fetch_stage i_fetch (
        .clk, .rst, .trigger_i, .imem_we_i, .imem_addr_i, .imem_wdata_i,
        .redirect_i   (redirect_e),
        .target_i     (target_e),
        .hz           (hz.fetch),
        .instr_d_o    (instr_d),
        .pc_d_o       (pc_d),
        .pc_plus4_d_o (pc_plus4_d),
        .valid_d_o    (valid_d)
    );

    decode_stage i_decode (
        .clk, .rst,
        .instr_d_i    (instr_d),
        .pc_d_i       (pc_d),
        .pc_plus4_d_i (pc_plus4_d),
        .valid_d_i    (valid_d),
        .wb_en_i      (wb_en),
        .wb_rd_i      (wb_rd),
        .wb_data_i    (wb_data),
        .hz           (hz.decode),
        .ctrl_e_o     (ctrl_e),
        .rs1_val_e_o  (rs1_val_e),
        .rs2_val_e_o  (rs2_val_e),
        .imm_e_o      (imm_e),
        .pc_e_o       (pc_e),
        .pc_plus4_e_o (pc_plus4_e),
        .rd_e_o       (rd_e),
        .rs1_e_o      (rs1_e),
        .rs2_e_o      (rs2_e),
        .a0_o
    );

    execute_stage i_execute (
        .clk, .rst,
        .ctrl_e_i       (ctrl_e),
        .rs1_val_e_i    (rs1_val_e),
        .rs2_val_e_i    (rs2_val_e),
        .imm_e_i        (imm_e),
        .pc_e_i         (pc_e),
        .pc_plus4_e_i   (pc_plus4_e),
        .rd_e_i         (rd_e),
        .rs1_e_i        (rs1_e),
        .rs2_e_i        (rs2_e),
        .wb_data_i      (wb_data),
        .hz             (hz.execute),
        .redirect_o     (redirect_e),
        .target_o       (target_e),
        .ctrl_m_o       (ctrl_m),
        .alu_result_m_o (alu_result_m),
        .store_data_m_o (store_data_m),
        .pc_plus4_m_o   (pc_plus4_m),
        .rd_m_o         (rd_m)
    );

    mem_wb_stage i_mem_wb (
        .clk, .rst,
        .ctrl_m_i       (ctrl_m),
        .alu_result_m_i (alu_result_m),
        .store_data_m_i (store_data_m),
        .pc_plus4_m_i   (pc_plus4_m),
        .rd_m_i         (rd_m),
        .hz             (hz.mem_wb),
        .wb_en_o        (wb_en),
        .wb_rd_o        (wb_rd),
        .wb_data_o      (wb_data)
    );

    hazard_unit i_hazard (
        .hz (hz.hazard)
    );

endmodule

`default_nettype wire

/* rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath width and register count
`define XLEN 32
`define NREGS 32

// memory depths in 32-bit words, indexed by address bits above bit 1
`define IMEM_WORDS 256
`define DMEM_WORDS 256
`define IMEM_AW 8

`define RESET_PC 32'h0000_0000

`endif

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_WB,
        FWD_MEM
    } fwd_sel_e;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_LINK   // pc + 4
    } res_sel_e;

    // decoded control, all zero is a bubble
    typedef struct packed {
        logic     reg_wr;
        logic     mem_wr;
        logic     mem_rd;
        logic     branch;
        logic     branch_ne;
        logic     jump;
        logic     jalr;
        logic     alu_src_imm;
        alu_op_e  alu_op;
        res_sel_e res_sel;
    } ctrl_t;

endpackage

`default_nettype wire

/* tb.f */
+incdir+.
rv_pkg.sv
hazard_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
hazard_unit.sv
rv_core_top.sv
tb_clock.sv
tb_rv_core.sv

/* tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;  // 8 ns period
    end

    // power-on reset, 3 cycles
    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`include "rv_defines.svh"
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [4:0] A0 = 5'd10;
    localparam int WAIT_LIMIT = 300;

    logic                clk;
    logic                por_rst;
    logic                tb_rst;
    logic                rst;
    logic                trigger;
    logic                imem_we;
    logic [`IMEM_AW-1:0] imem_addr;
    logic [`XLEN-1:0]    imem_wdata;
    logic [`XLEN-1:0]    a0;
    logic [31:0]         prog [$];   // program under construction
    logic [31:0]         lfsr_state;

    assign rst = por_rst | tb_rst;

    tb_clock i_tb_clock (.clk_o(clk), .rst_o(por_rst));

    rv_core_top i_rv_core_top (
        .clk, .rst,
        .trigger_i    (trigger),
        .imem_we_i    (imem_we),
        .imem_addr_i  (imem_addr),
        .imem_wdata_i (imem_wdata),
        .a0_o         (a0)
    );

    // instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};  // sw only
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_imm12(output logic [11:0] imm);
        int b;
        imm = '0;
        for (b = 0; b < 12; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            imm = {imm[10:0], lfsr_state[0]};
        end
    endtask

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        tb_rst  <= 1'b1;
        trigger <= 1'b0;
        imem_we <= 1'b0;
        repeat (3) @(posedge clk);
        tb_rst <= 1'b0;
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= i[`IMEM_AW-1:0];
            imem_wdata <= prog[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic pulse_trigger();
        @(posedge clk);
        trigger <= 1'b1;
        @(posedge clk);
        trigger <= 1'b0;
    endtask

    task automatic wait_for_a0(input logic [31:0] exp);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (a0 !== exp && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (a0 !== exp) begin
            $display("timeout: a0_o did not reach 0x%08h within %0d cycles",
                     exp, WAIT_LIMIT);
        end
    endtask

    task automatic run_program(input logic [31:0] exp);
        apply_reset();
        load_program();
        pulse_trigger();
        wait_for_a0(exp);
        check_value("a0_o", a0, exp);
        repeat (12) @(negedge clk);
        check_value("a0_o", a0, exp);  // parked in its loop, must not move
    endtask

    task automatic test_alu_forwarding();
        logic [31:0] x6, x7, x8, x9, a;
        prog.delete();
        emit(u_type(20'h12345, 5'd6));
        emit(i_type(12'h678, 5'd6, F3_OR, 5'd6, OPC_IMM));
        emit(i_type(12'd5, 5'd0, F3_ADD, 5'd7, OPC_IMM));
        emit(r_type(7'h00, 5'd7, 5'd6, F3_ADD, A0));  // x6 from wb, x7 from mem
        emit(i_type(12'hff0, 5'd0, F3_ADD, 5'd8, OPC_IMM));
        emit(r_type(7'h20, 5'd8, A0, F3_ADD, A0));    // sub
        emit(r_type(7'h00, 5'd6, A0, F3_AND, A0));
        emit(r_type(7'h00, 5'd7, A0, F3_OR, A0));
        emit(r_type(7'h00, 5'd8, A0, F3_XOR, A0));
        emit(r_type(7'h00, 5'd0, A0, F3_SLT, 5'd9));
        emit(r_type(7'h00, 5'd7, 5'd9, F3_ADD, 5'd9));
        emit(r_type(7'h00, 5'd9, A0, F3_SLL, A0));
        emit(r_type(7'h00, 5'd7, A0, F3_SRL, A0));
        emit(r_type(7'h00, 5'd9, A0, F3_ADD, A0));
        emit(j_type(21'd0, 5'd0));
        x6 = {20'h12345, 12'h000} | 32'h0000_0678;
        x7 = 32'd5;
        a  = x6 + x7;
        x8 = 32'hffff_fff0;
        a  = a - x8;
        a  = a & x6;
        a  = a | x7;
        a  = a ^ x8;
        x9 = ($signed(a) < 0) ? 32'd1 : 32'd0;
        x9 = x9 + x7;
        a  = a << x9[4:0];
        a  = a >> x7[4:0];
        a  = a + x9;
        run_program(a);
    endtask

    task automatic test_load_use();
        logic [31:0] stored;
        prog.delete();
        emit(i_type(12'h040, 5'd0, F3_ADD, 5'd5, OPC_IMM));
        emit(u_type(20'habcde, 5'd6));
        emit(i_type(12'h123, 5'd6, F3_ADD, 5'd6, OPC_IMM));
        emit(s_type(12'd8, 5'd6, 5'd5));
        emit(i_type(12'd8, 5'd5, 3'b010, 5'd7, OPC_LOAD));
        emit(i_type(12'h055, 5'd7, F3_ADD, A0, OPC_IMM));  // consumer right behind lw
        emit(j_type(21'd0, 5'd0));
        stored = {20'habcde, 12'h000} + 32'h0000_0123;
        run_program(stored + 32'h0000_0055);
    endtask

    task automatic test_branches();
        logic [31:0] x5, x6, x7, exp;
        prog.delete();
        emit(i_type(12'd1, 5'd0, F3_ADD, A0, OPC_IMM));
        emit(i_type(12'd7, 5'd0, F3_ADD, 5'd5, OPC_IMM));
        emit(i_type(12'd7, 5'd0, F3_ADD, 5'd6, OPC_IMM));
        emit(b_type(13'd12, 5'd6, 5'd5, 3'b000));          // beq over two
        emit(i_type(12'd100, A0, F3_ADD, A0, OPC_IMM));
        emit(i_type(12'd200, A0, F3_ADD, A0, OPC_IMM));
        emit(i_type(12'd2, A0, F3_ADD, A0, OPC_IMM));
        emit(b_type(13'd8, 5'd6, 5'd5, 3'b001));           // bne
        emit(i_type(12'd4, A0, F3_ADD, A0, OPC_IMM));
        emit(i_type(12'd3, 5'd0, F3_ADD, 5'd7, OPC_IMM));
        emit(b_type(13'd8, 5'd7, 5'd5, 3'b001));           // bne on fresh x7
        emit(i_type(12'd64, A0, F3_ADD, A0, OPC_IMM));
        emit(i_type(12'd16, A0, F3_ADD, A0, OPC_IMM));
        emit(j_type(21'd0, 5'd0));
        x5  = 32'd7;
        x6  = 32'd7;
        x7  = 32'd3;
        exp = 32'd1;
        if (x5 != x6) exp = exp + 32'd300;
        exp = exp + 32'd2;
        if (x5 == x6) exp = exp + 32'd4;
        if (x5 == x7) exp = exp + 32'd64;
        exp = exp + 32'd16;
        run_program(exp);
    endtask

    task automatic test_jumps();
        logic [31:0] jal_pc;
        prog.delete();
        emit(i_type(12'd28, 5'd0, F3_ADD, 5'd11, OPC_IMM));  // jalr base
        emit(j_type(21'd8, 5'd1));                          // pc 4, jal x1 +8
        emit(i_type(12'd99, 5'd0, F3_ADD, A0, OPC_IMM));
        emit(i_type(12'd0, 5'd1, F3_ADD, A0, OPC_IMM));     // a0 = x1
        emit(i_type(12'd5, 5'd11, 3'b000, 5'd12, OPC_JALR)); // (28+5) & ~1 = 32
        emit(i_type(12'd0, 5'd0, F3_ADD, A0, OPC_IMM));
        emit(i_type(12'd55, A0, F3_ADD, A0, OPC_IMM));
        emit(i_type(12'd77, 5'd0, F3_ADD, A0, OPC_IMM));
        emit(j_type(21'd0, 5'd0));                          // pc 32
        jal_pc = 32'd4;
        run_program(jal_pc + 32'd4);
    endtask

    task automatic test_trigger_gating();
        logic [31:0] exp;
        int n;
        prog.delete();
        emit(u_type(20'h5a5a5, A0));
        emit(i_type(12'h3c3, A0, F3_OR, A0, OPC_IMM));
        emit(j_type(21'd0, 5'd0));
        exp = {20'h5a5a5, 12'h000} | 32'h0000_03c3;
        apply_reset();
        load_program();
        for (n = 0; n < 20; n++) begin
            @(negedge clk);
            check_value("a0_o", a0, 32'd0);  // core idle without trigger
        end
        pulse_trigger();
        wait_for_a0(exp);
        check_value("a0_o", a0, exp);
        apply_reset();
        for (n = 0; n < 5; n++) begin
            @(negedge clk);
            check_value("a0_o", a0, 32'd0);
        end
    endtask

    task automatic test_random_imm();
        logic [11:0] imm;
        logic [31:0] exp;
        int k;
        prog.delete();
        exp = 32'd0;
        for (k = 0; k < 12; k++) begin
            draw_imm12(imm);
            if (k % 2 == 0) begin
                emit(i_type(imm, A0, F3_ADD, A0, OPC_IMM));
                exp = exp + {{20{imm[11]}}, imm};
            end else begin
                emit(i_type(imm, A0, F3_XOR, A0, OPC_IMM));
                exp = exp ^ {{20{imm[11]}}, imm};
            end
        end
        emit(j_type(21'd0, 5'd0));
        run_program(exp);
    endtask

    initial begin
        tb_rst     = 1'b0;
        trigger    = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        lfsr_state = 32'h03e0_026e;
        test_alu_forwarding();
        test_load_use();
        test_branches();
        test_jumps();
        test_trigger_gating();
        test_random_imm();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
